// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_usb_bridge
FILE_LIST  := files.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG   := TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(OBJ_DIR)

// File: access_arbiter.sv
`timescale 1ns/1ps

module access_arbiter (
  input  logic              clk,
  input  logic              rst_n,
  bus_access_if.responder   hc_link,
  bus_access_if.responder   dc_link,
  bus_access_if.requester   seq_link
);

  logic                   grant_valid;
  // holds the current grant, and after release the last port that was served.
  usb_bridge_pkg::port_e  grant_port;
  usb_bridge_pkg::port_e  next_port;
  logic                   grant_hc;
  logic                   grant_dc;
  logic                   pick_dc;

  assign grant_hc = grant_valid && (grant_port == usb_bridge_pkg::port_hc);
  assign grant_dc = grant_valid && (grant_port == usb_bridge_pkg::port_dc);
  assign pick_dc  = (grant_port == usb_bridge_pkg::port_dc);

  // on a tie the port that was not served last goes first.
  always_comb begin
    if (hc_link.req && dc_link.req) begin
      next_port = pick_dc ? usb_bridge_pkg::port_hc : usb_bridge_pkg::port_dc;
    end else if (dc_link.req) begin
      next_port = usb_bridge_pkg::port_dc;
    end else begin
      next_port = usb_bridge_pkg::port_hc;
    end
  end

  assign seq_link.req     = grant_hc ? hc_link.req : (grant_dc ? dc_link.req : 1'b0);
  assign seq_link.write   = pick_dc ? dc_link.write   : hc_link.write;
  assign seq_link.reg_sel = pick_dc ? dc_link.reg_sel : hc_link.reg_sel;
  assign seq_link.port    = pick_dc ? dc_link.port    : hc_link.port;
  assign seq_link.wdata   = pick_dc ? dc_link.wdata   : hc_link.wdata;

  assign hc_link.ack   = grant_hc && seq_link.ack;
  assign dc_link.ack   = grant_dc && seq_link.ack;
  assign hc_link.rdata = grant_hc ? seq_link.rdata : '0;
  assign dc_link.rdata = grant_dc ? seq_link.rdata : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      grant_valid <= 1'b0;
      grant_port  <= usb_bridge_pkg::port_dc;
    end else if (!grant_valid) begin
      if (!seq_link.ack && (hc_link.req || dc_link.req)) begin
        grant_valid <= 1'b1;
        grant_port  <= next_port;
      end
    end else if (!seq_link.req && !seq_link.ack) begin
      // the granted port has finished all four phases.
      grant_valid <= 1'b0;
    end
  end

endmodule

// File: bus_access_if.sv
`timescale 1ns/1ps

// one single-word access between two stages, four-phase req/ack.
interface bus_access_if;

  logic                       req;
  logic                       write;
  usb_bridge_pkg::reg_sel_t   reg_sel;
  usb_bridge_pkg::port_e      port;
  usb_bridge_pkg::data_t      wdata;
  logic                       ack;
  usb_bridge_pkg::data_t      rdata;

  modport requester (
    output req,
    output write,
    output reg_sel,
    output port,
    output wdata,
    input  ack,
    input  rdata
  );

  modport responder (
    input  req,
    input  write,
    input  reg_sel,
    input  port,
    input  wdata,
    output ack,
    output rdata
  );

endinterface

// File: chip_bus_sequencer.sv
`timescale 1ns/1ps

module chip_bus_sequencer (
  input  logic                        clk,
  input  logic                        rst_n,
  bus_access_if.responder             link,
  output usb_bridge_pkg::chip_addr_t  usb_addr,
  output usb_bridge_pkg::data_t       usb_data_out,
  output logic                        usb_data_oe,
  input  usb_bridge_pkg::data_t       usb_data_in,
  output logic                        usb_cs_n,
  output logic                        usb_rd_n,
  output logic                        usb_wr_n,
  output logic                        usb_rst_n
);

  usb_bridge_pkg::seq_state_e  state;
  usb_bridge_pkg::cycle_cnt_t  cnt;
  logic                        phase_end;
  logic                        op_write;
  logic                        ack_q;

  assign link.ack = ack_q;

  always_comb begin
    case (state)
      usb_bridge_pkg::seq_reset:
        phase_end = cnt == usb_bridge_pkg::cycle_cnt_t'(usb_bridge_pkg::CHIP_RESET_CYCLES - 1);
      usb_bridge_pkg::seq_setup:
        phase_end = cnt == usb_bridge_pkg::cycle_cnt_t'(usb_bridge_pkg::SETUP_CYCLES - 1);
      usb_bridge_pkg::seq_strobe:
        phase_end = cnt == usb_bridge_pkg::cycle_cnt_t'(usb_bridge_pkg::STROBE_CYCLES - 1);
      usb_bridge_pkg::seq_hold:
        phase_end = cnt == usb_bridge_pkg::cycle_cnt_t'(usb_bridge_pkg::HOLD_CYCLES - 1);
      usb_bridge_pkg::seq_recover:
        phase_end = cnt == usb_bridge_pkg::cycle_cnt_t'(usb_bridge_pkg::RECOVER_CYCLES - 1);
      default:
        phase_end = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= usb_bridge_pkg::seq_reset;
      cnt         <= '0;
      usb_rst_n   <= 1'b0;
      usb_cs_n    <= 1'b1;
      usb_rd_n    <= 1'b1;
      usb_wr_n    <= 1'b1;
      usb_data_oe <= 1'b0;
      usb_addr    <= '0;
      op_write    <= 1'b0;
      ack_q       <= 1'b0;
    end else begin
      cnt <= phase_end ? '0 : cnt + 1'b1;
      case (state)
        usb_bridge_pkg::seq_reset: begin
          if (phase_end) begin
            usb_rst_n <= 1'b1;
            state     <= usb_bridge_pkg::seq_idle;
          end
        end
        usb_bridge_pkg::seq_idle: begin
          cnt <= '0;
          if (link.req) begin
            usb_cs_n    <= 1'b0;
            usb_addr    <= {link.port, link.reg_sel};
            usb_data_oe <= link.write;
            op_write    <= link.write;
            state       <= usb_bridge_pkg::seq_setup;
          end
        end
        usb_bridge_pkg::seq_setup: begin
          if (phase_end) begin
            usb_rd_n <= op_write;
            usb_wr_n <= !op_write;
            state    <= usb_bridge_pkg::seq_strobe;
          end
        end
        usb_bridge_pkg::seq_strobe: begin
          if (phase_end) begin
            usb_rd_n <= 1'b1;
            usb_wr_n <= 1'b1;
            state    <= usb_bridge_pkg::seq_hold;
          end
        end
        usb_bridge_pkg::seq_hold: begin
          if (phase_end) begin
            usb_cs_n    <= 1'b1;
            usb_data_oe <= 1'b0;
            ack_q       <= 1'b1;
            state       <= usb_bridge_pkg::seq_recover;
          end
        end
        usb_bridge_pkg::seq_recover: begin
          // recovery is only counted once the handshake has closed.
          if (ack_q) begin
            cnt <= '0;
            if (!link.req) begin
              ack_q <= 1'b0;
            end
          end else if (phase_end) begin
            state <= usb_bridge_pkg::seq_idle;
          end
        end
        default: state <= usb_bridge_pkg::seq_reset;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == usb_bridge_pkg::seq_idle && link.req) begin
      usb_data_out <= link.wdata;
    end
    // the chip has had the whole strobe to settle its read data.
    if (state == usb_bridge_pkg::seq_strobe && phase_end && !op_write) begin
      link.rdata <= usb_data_in;
    end
  end

endmodule

// File: files.f
usb_bridge_pkg.sv
bus_access_if.sv
host_port.sv
access_arbiter.sv
chip_bus_sequencer.sv
usb_bridge_top.sv
isp_chip_model.sv
usb_bridge_assertions.sv
tb_usb_bridge.sv

// File: host_port.sv
`timescale 1ns/1ps

module host_port (
  input  logic                   clk,
  input  logic                   rst_n,
  input  usb_bridge_pkg::port_e  port_id,
  input  logic                   host_req,
  input  logic                   host_write,
  input  logic                   host_reg_sel,
  input  usb_bridge_pkg::data_t  host_wdata,
  output logic                   host_ack,
  output usb_bridge_pkg::data_t  host_rdata,
  input  logic                   chip_int,
  output logic                   irq_n,
  bus_access_if.requester        link
);

  typedef enum logic [1:0] {
    hp_idle,
    hp_wait_ack,
    hp_wait_release
  } hp_state_e;

  hp_state_e                 state;
  logic                      req_q;
  logic                      write_q;
  usb_bridge_pkg::reg_sel_t  reg_sel_q;
  usb_bridge_pkg::data_t     wdata_q;
  logic [1:0]                irq_sync;
  logic                      start;
  logic                      finish;

  // a new access may only begin once the previous internal ack has dropped.
  assign start  = (state == hp_idle) && host_req && !link.ack;
  assign finish = (state == hp_wait_ack) && link.ack;

  assign link.req     = req_q;
  assign link.write   = write_q;
  assign link.reg_sel = reg_sel_q;
  assign link.port    = port_id;
  assign link.wdata   = wdata_q;
  assign irq_n        = irq_sync[1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= hp_idle;
      req_q    <= 1'b0;
      host_ack <= 1'b0;
    end else begin
      case (state)
        hp_idle: begin
          if (start) begin
            req_q <= 1'b1;
            state <= hp_wait_ack;
          end
        end
        hp_wait_ack: begin
          if (finish) begin
            req_q    <= 1'b0;
            host_ack <= 1'b1;
            state    <= hp_wait_release;
          end
        end
        hp_wait_release: begin
          if (!host_req) begin
            host_ack <= 1'b0;
            state    <= hp_idle;
          end
        end
        default: state <= hp_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      write_q   <= host_write;
      reg_sel_q <= host_reg_sel;
      wdata_q   <= host_wdata;
    end
    // read data stays on host_rdata until a later read replaces it.
    if (finish && !write_q) begin
      host_rdata <= link.rdata;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      irq_sync <= 2'b11;
    end else begin
      irq_sync <= {irq_sync[0], chip_int};
    end
  end

endmodule

// File: isp_chip_model.sv
`timescale 1ns/1ps

// behavioral model of the chip side of the shared bus, four 16-bit registers.
module isp_chip_model (
  input  usb_bridge_pkg::chip_addr_t  usb_addr,
  input  usb_bridge_pkg::data_t       usb_data_out,
  input  logic                        usb_data_oe,
  output usb_bridge_pkg::data_t       usb_data_in,
  input  logic                        usb_cs_n,
  input  logic                        usb_rd_n,
  input  logic                        usb_wr_n,
  input  logic                        usb_rst_n
);

  usb_bridge_pkg::data_t  regs [4];

  // the chip latches write data when the write strobe is released.
  always @(posedge usb_wr_n or negedge usb_rst_n) begin
    if (!usb_rst_n) begin
      for (int i = 0; i < 4; i++) begin
        regs[i] <= '0;
      end
    end else if (!usb_cs_n && usb_data_oe) begin
      regs[usb_addr] <= usb_data_out;
    end
  end

  assign usb_data_in = (!usb_rd_n && !usb_cs_n) ? regs[usb_addr] : '0;

endmodule

// File: tb_usb_bridge.sv
`timescale 1ns/1ps

module tb_usb_bridge;

  localparam int unsigned TIMEOUT_CYCLES = 200;
  localparam int unsigned IRQ_CYCLES     = 3;
  localparam int unsigned NUM_STEPS      = 12;
  localparam int unsigned NUM_COLLISIONS = 6;

  typedef struct packed {
    usb_bridge_pkg::port_e     port;
    logic                      write;
    usb_bridge_pkg::reg_sel_t  reg_sel;
    usb_bridge_pkg::data_t     wdata;
    usb_bridge_pkg::data_t     exp_rdata;
  } step_t;

  logic                        clk;
  logic                        rst_n;
  logic                        hc_req;
  logic                        hc_ack;
  logic                        hc_write;
  logic                        hc_reg_sel;
  usb_bridge_pkg::data_t       hc_wdata;
  usb_bridge_pkg::data_t       hc_rdata;
  logic                        hc_irq_n;
  logic                        dc_req;
  logic                        dc_ack;
  logic                        dc_write;
  logic                        dc_reg_sel;
  usb_bridge_pkg::data_t       dc_wdata;
  usb_bridge_pkg::data_t       dc_rdata;
  logic                        dc_irq_n;
  usb_bridge_pkg::chip_addr_t  usb_addr;
  usb_bridge_pkg::data_t       usb_data_out;
  logic                        usb_data_oe;
  usb_bridge_pkg::data_t       usb_data_in;
  logic                        usb_cs_n;
  logic                        usb_rd_n;
  logic                        usb_wr_n;
  logic                        usb_rst_n;
  logic                        usb_int0;
  logic                        usb_int1;

  // chip bus fields seen in the last selected cycle.
  usb_bridge_pkg::chip_addr_t  seen_addr;
  usb_bridge_pkg::data_t       seen_wdata;
  logic                        seen_oe;

  // expected register contents, indexed like the chip address.
  usb_bridge_pkg::data_t  shadow [4];
  usb_bridge_pkg::port_e  ack_order [$];
  step_t                  steps [NUM_STEPS];
  int unsigned            checks;
  int unsigned            errors;
  int unsigned            timeouts;

  usb_bridge_top i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .hc_req       (hc_req),
    .hc_ack       (hc_ack),
    .hc_write     (hc_write),
    .hc_reg_sel   (hc_reg_sel),
    .hc_wdata     (hc_wdata),
    .hc_rdata     (hc_rdata),
    .hc_irq_n     (hc_irq_n),
    .dc_req       (dc_req),
    .dc_ack       (dc_ack),
    .dc_write     (dc_write),
    .dc_reg_sel   (dc_reg_sel),
    .dc_wdata     (dc_wdata),
    .dc_rdata     (dc_rdata),
    .dc_irq_n     (dc_irq_n),
    .usb_addr     (usb_addr),
    .usb_data_out (usb_data_out),
    .usb_data_oe  (usb_data_oe),
    .usb_data_in  (usb_data_in),
    .usb_cs_n     (usb_cs_n),
    .usb_rd_n     (usb_rd_n),
    .usb_wr_n     (usb_wr_n),
    .usb_rst_n    (usb_rst_n),
    .usb_int0     (usb_int0),
    .usb_int1     (usb_int1)
  );

  isp_chip_model i_chip (
    .usb_addr     (usb_addr),
    .usb_data_out (usb_data_out),
    .usb_data_oe  (usb_data_oe),
    .usb_data_in  (usb_data_in),
    .usb_cs_n     (usb_cs_n),
    .usb_rd_n     (usb_rd_n),
    .usb_wr_n     (usb_wr_n),
    .usb_rst_n    (usb_rst_n)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(negedge clk) begin
    if (!usb_cs_n) begin
      seen_addr  <= usb_addr;
      seen_wdata <= usb_data_out;
      seen_oe    <= usb_data_oe;
    end
  end

  task automatic check_data(input usb_bridge_pkg::data_t actual,
                            input usb_bridge_pkg::data_t expected, input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic check_level(input logic actual, input logic expected, input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED at %0t: %s, got %b expected %b", $time, what, actual, expected);
    end
  endtask

  task automatic check_addr(input usb_bridge_pkg::chip_addr_t actual,
                            input usb_bridge_pkg::chip_addr_t expected, input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED at %0t: %s, got %b expected %b", $time, what, actual, expected);
    end
  endtask

  task automatic check_port(input usb_bridge_pkg::port_e actual,
                            input usb_bridge_pkg::port_e expected, input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED at %0t: %s, got %s expected %s", $time, what,
               actual.name(), expected.name());
    end
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("TIMEOUT at %0t: %s did not happen within %0d cycles", $time, what,
             TIMEOUT_CYCLES);
  endtask

  function automatic usb_bridge_pkg::port_e other_port(input usb_bridge_pkg::port_e port);
    return (port == usb_bridge_pkg::port_hc) ? usb_bridge_pkg::port_dc : usb_bridge_pkg::port_hc;
  endfunction

  // bit 1 of the chip address is the controller and bit 0 the register.
  function automatic usb_bridge_pkg::chip_addr_t addr_of(input usb_bridge_pkg::port_e port,
                                                         input usb_bridge_pkg::reg_sel_t sel);
    return {port, sel};
  endfunction

  function automatic logic ack_of(input usb_bridge_pkg::port_e port);
    return (port == usb_bridge_pkg::port_hc) ? hc_ack : dc_ack;
  endfunction

  function automatic logic irq_of(input usb_bridge_pkg::port_e port);
    return (port == usb_bridge_pkg::port_hc) ? hc_irq_n : dc_irq_n;
  endfunction

  task automatic drive_port(input usb_bridge_pkg::port_e port, input logic req,
                            input logic write, input usb_bridge_pkg::reg_sel_t sel,
                            input usb_bridge_pkg::data_t wdata);
    if (port == usb_bridge_pkg::port_hc) begin
      hc_req     = req;
      hc_write   = write;
      hc_reg_sel = sel;
      hc_wdata   = wdata;
    end else begin
      dc_req     = req;
      dc_write   = write;
      dc_reg_sel = sel;
      dc_wdata   = wdata;
    end
  endtask

  // one complete four-phase access on a host port.
  task automatic run_access(input usb_bridge_pkg::port_e port, input logic write,
                            input usb_bridge_pkg::reg_sel_t sel,
                            input usb_bridge_pkg::data_t wdata,
                            output usb_bridge_pkg::data_t rdata);
    int unsigned waited;
    @(negedge clk);
    drive_port(port, 1'b1, write, sel, wdata);
    waited = 0;
    while (!ack_of(port) && waited < TIMEOUT_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    rdata = (port == usb_bridge_pkg::port_hc) ? hc_rdata : dc_rdata;
    if (ack_of(port)) begin
      ack_order.push_back(port);
    end else begin
      report_timeout($sformatf("ack rise on the %s port", port.name()));
    end
    drive_port(port, 1'b0, write, sel, wdata);
    waited = 0;
    while (ack_of(port) && waited < TIMEOUT_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    if (ack_of(port)) begin
      report_timeout($sformatf("ack fall on the %s port", port.name()));
    end
  endtask

  task automatic collide(input logic write, input usb_bridge_pkg::reg_sel_t sel,
                         input usb_bridge_pkg::data_t wd_hc, input usb_bridge_pkg::data_t wd_dc,
                         output usb_bridge_pkg::data_t rd_hc, output usb_bridge_pkg::data_t rd_dc);
    ack_order.delete();
    fork
      run_access(usb_bridge_pkg::port_hc, write, sel, wd_hc, rd_hc);
      run_access(usb_bridge_pkg::port_dc, write, sel, wd_dc, rd_dc);
    join
  endtask

  task automatic check_grants(input usb_bridge_pkg::port_e first);
    if (ack_order.size() == 2) begin
      check_port(ack_order[0], first, "first grant of a collision");
      check_port(ack_order[1], other_port(first), "second grant of a collision");
    end
  endtask

  task automatic toggle_irq(input usb_bridge_pkg::port_e port, input logic level);
    int unsigned waited;
    @(negedge clk);
    if (port == usb_bridge_pkg::port_hc) begin
      usb_int0 = level;
    end else begin
      usb_int1 = level;
    end
    waited = 0;
    while (irq_of(port) !== level && waited < IRQ_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    check_level(hc_irq_n, usb_int0, "hc_irq_n follows usb_int0");
    check_level(dc_irq_n, usb_int1, "dc_irq_n follows usb_int1");
  endtask

  initial begin
    usb_bridge_pkg::data_t     rd_hc;
    usb_bridge_pkg::data_t     rd_dc;
    usb_bridge_pkg::data_t     wd_hc;
    usb_bridge_pkg::data_t     wd_dc;
    usb_bridge_pkg::port_e     last_port;
    usb_bridge_pkg::port_e     winner;
    usb_bridge_pkg::port_e     solo_port;
    usb_bridge_pkg::reg_sel_t  sel;
    int unsigned               low_cycles;
    logic                      early_ack;
    logic                      early_access;

    void'($urandom(32'had65e01f));
    checks       = 0;
    errors       = 0;
    timeouts     = 0;
    rst_n        = 1'b0;
    usb_int0     = 1'b1;
    usb_int1     = 1'b1;
    low_cycles   = 0;
    early_ack    = 1'b0;
    early_access = 1'b0;
    last_port    = usb_bridge_pkg::port_hc;
    drive_port(usb_bridge_pkg::port_hc, 1'b0, 1'b0, 1'b0, '0);
    drive_port(usb_bridge_pkg::port_dc, 1'b0, 1'b0, 1'b0, '0);
    for (int i = 0; i < 4; i++) begin
      shadow[i] = '0;
    end

    steps = '{
      '{usb_bridge_pkg::port_hc, 1'b0, 1'b0, 16'h0000, 16'h0000},
      '{usb_bridge_pkg::port_hc, 1'b1, 1'b0, 16'h1234, 16'h0000},
      '{usb_bridge_pkg::port_hc, 1'b0, 1'b0, 16'h0000, 16'h1234},
      '{usb_bridge_pkg::port_dc, 1'b0, 1'b0, 16'h0000, 16'h0000},
      '{usb_bridge_pkg::port_dc, 1'b1, 1'b0, 16'habcd, 16'h0000},
      '{usb_bridge_pkg::port_dc, 1'b0, 1'b0, 16'h0000, 16'habcd},
      '{usb_bridge_pkg::port_hc, 1'b0, 1'b0, 16'h0000, 16'h1234},
      '{usb_bridge_pkg::port_hc, 1'b1, 1'b1, 16'h5a5a, 16'h0000},
      '{usb_bridge_pkg::port_dc, 1'b1, 1'b1, 16'h0f0f, 16'h0000},
      '{usb_bridge_pkg::port_hc, 1'b0, 1'b1, 16'h0000, 16'h5a5a},
      '{usb_bridge_pkg::port_dc, 1'b0, 1'b1, 16'h0000, 16'h0f0f},
      '{usb_bridge_pkg::port_hc, 1'b0, 1'b0, 16'h0000, 16'h1234}
    };

    repeat (10) @(negedge clk);
    check_level(usb_cs_n, 1'b1, "usb_cs_n in reset");
    check_level(usb_rd_n, 1'b1, "usb_rd_n in reset");
    check_level(usb_wr_n, 1'b1, "usb_wr_n in reset");
    check_level(usb_data_oe, 1'b0, "usb_data_oe in reset");
    check_level(usb_rst_n, 1'b0, "usb_rst_n in reset");
    check_level(hc_ack, 1'b0, "hc_ack in reset");
    check_level(dc_ack, 1'b0, "dc_ack in reset");
    rst_n = 1'b1;

    // a read issued while the chip is still in reset must wait for it.
    fork
      run_access(usb_bridge_pkg::port_hc, 1'b0, 1'b0, '0, rd_hc);
      while (!usb_rst_n && low_cycles < TIMEOUT_CYCLES) begin
        early_ack    = early_ack | hc_ack;
        early_access = early_access | !usb_cs_n;
        low_cycles++;
        @(negedge clk);
      end
    join
    check_level(usb_rst_n, 1'b1, "usb_rst_n released");
    check_level(low_cycles >= usb_bridge_pkg::CHIP_RESET_CYCLES, 1'b1, "chip reset length");
    check_level(early_ack, 1'b0, "hc_ack during chip reset");
    check_level(early_access, 1'b0, "usb_cs_n during chip reset");
    check_data(rd_hc, 16'h0000, "read issued during chip reset");

    for (int i = 0; i < NUM_STEPS; i++) begin
      run_access(steps[i].port, steps[i].write, steps[i].reg_sel, steps[i].wdata, rd_hc);
      check_addr(seen_addr, addr_of(steps[i].port, steps[i].reg_sel),
                 $sformatf("chip address of table step %0d", i));
      check_level(seen_oe, steps[i].write, $sformatf("data enable of table step %0d", i));
      if (steps[i].write) begin
        check_data(seen_wdata, steps[i].wdata, $sformatf("chip write data of table step %0d", i));
        shadow[addr_of(steps[i].port, steps[i].reg_sel)] = steps[i].wdata;
      end else begin
        check_data(rd_hc, steps[i].exp_rdata, $sformatf("table step %0d", i));
      end
      last_port = steps[i].port;
    end

    for (int k = 0; k < NUM_COLLISIONS; k++) begin
      // an odd round first serves one port alone to move the last grant.
      if (k % 2 == 1) begin
        solo_port = (1'($urandom()) == 1'b1) ? usb_bridge_pkg::port_dc : usb_bridge_pkg::port_hc;
        sel       = 1'($urandom());
        run_access(solo_port, 1'b0, sel, '0, rd_hc);
        check_data(rd_hc, shadow[addr_of(solo_port, sel)], "single read between collisions");
        last_port = solo_port;
      end
      sel   = 1'($urandom());
      wd_hc = usb_bridge_pkg::data_t'($urandom());
      wd_dc = usb_bridge_pkg::data_t'($urandom());
      collide(1'b1, sel, wd_hc, wd_dc, rd_hc, rd_dc);
      winner = other_port(last_port);
      check_grants(winner);
      last_port = other_port(winner);
      shadow[addr_of(usb_bridge_pkg::port_hc, sel)] = wd_hc;
      shadow[addr_of(usb_bridge_pkg::port_dc, sel)] = wd_dc;
      collide(1'b0, sel, '0, '0, rd_hc, rd_dc);
      check_data(rd_hc, shadow[addr_of(usb_bridge_pkg::port_hc, sel)], "hc read in collision");
      check_data(rd_dc, shadow[addr_of(usb_bridge_pkg::port_dc, sel)], "dc read in collision");
      winner = other_port(last_port);
      check_grants(winner);
      last_port = other_port(winner);
    end

    toggle_irq(usb_bridge_pkg::port_hc, 1'b0);
    toggle_irq(usb_bridge_pkg::port_dc, 1'b0);
    toggle_irq(usb_bridge_pkg::port_hc, 1'b1);
    toggle_irq(usb_bridge_pkg::port_dc, 1'b1);
    toggle_irq(usb_bridge_pkg::port_dc, 1'b0);
    toggle_irq(usb_bridge_pkg::port_dc, 1'b1);

    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: usb_bridge_assertions.sv
`timescale 1ns/1ps

module usb_bridge_assertions (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  usb_cs_n,
  input  logic  usb_rd_n,
  input  logic  usb_wr_n,
  input  logic  usb_rst_n
);

  logic         strobe;
  int unsigned  strobe_len;
  int unsigned  idle_len;

  assign strobe = !usb_rd_n || !usb_wr_n;

  // strobe_len counts low strobe cycles and idle_len counts deselected cycles.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      strobe_len <= 0;
      idle_len   <= usb_bridge_pkg::RECOVER_CYCLES;
    end else begin
      strobe_len <= strobe ? strobe_len + 1 : 0;
      if (!usb_cs_n) begin
        idle_len <= 0;
      end else if (idle_len < 255) begin
        idle_len <= idle_len + 1;
      end
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    $fell(strobe) |-> strobe_len == usb_bridge_pkg::STROBE_CYCLES)
    else $error("strobe length differs from STROBE_CYCLES");

  assert property (@(posedge clk) disable iff (!rst_n) strobe |-> !usb_cs_n)
    else $error("strobe active while cs_n is high");

  assert property (@(posedge clk) disable iff (!rst_n) $rose(strobe) |-> $past(!usb_cs_n))
    else $error("no setup cycle with cs_n low before the strobe");

  assert property (@(posedge clk) disable iff (!rst_n) $fell(strobe) |-> !usb_cs_n)
    else $error("no hold cycle with cs_n low after the strobe");

  assert property (@(posedge clk) disable iff (!rst_n) !(!usb_rd_n && !usb_wr_n))
    else $error("rd_n and wr_n low together");

  assert property (@(posedge clk) disable iff (!rst_n)
    $fell(usb_cs_n) |-> idle_len >= usb_bridge_pkg::RECOVER_CYCLES)
    else $error("access started inside the recovery time");

  assert property (@(posedge clk) disable iff (!rst_n) !usb_rst_n |-> usb_cs_n)
    else $error("access started while the chip is held in reset");

endmodule

bind chip_bus_sequencer usb_bridge_assertions i_assertions (
  .clk       (clk),
  .rst_n     (rst_n),
  .usb_cs_n  (usb_cs_n),
  .usb_rd_n  (usb_rd_n),
  .usb_wr_n  (usb_wr_n),
  .usb_rst_n (usb_rst_n)
);

// File: usb_bridge_pkg.sv
package usb_bridge_pkg;

  // one word on the shared chip data bus.
  typedef logic [15:0] data_t;

  // 0 is the command register and 1 is the data register.
  typedef logic reg_sel_t;

  // bit 1 picks the controller and bit 0 picks the register.
  typedef logic [1:0] chip_addr_t;

  // the enum value is placed directly on chip address bit 1.
  typedef enum logic {
    port_hc = 1'b0,
    port_dc = 1'b1
  } port_e;

  typedef enum logic [2:0] {
    seq_reset,
    seq_idle,
    seq_setup,
    seq_strobe,
    seq_hold,
    seq_recover
  } seq_state_e;

  // access phase lengths in clock cycles.
  localparam int unsigned SETUP_CYCLES      = 1;
  localparam int unsigned STROBE_CYCLES     = 3;
  localparam int unsigned HOLD_CYCLES       = 1;
  localparam int unsigned RECOVER_CYCLES    = 2;
  localparam int unsigned CHIP_RESET_CYCLES = 16;

  // the phase counter never needs to go beyond CHIP_RESET_CYCLES - 1.
  localparam int unsigned CYCLE_COUNT_W = $clog2(CHIP_RESET_CYCLES);

  typedef logic [CYCLE_COUNT_W-1:0] cycle_cnt_t;

endpackage

// File: usb_bridge_top.sv
`timescale 1ns/1ps

module usb_bridge_top (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        hc_req,
  output logic                        hc_ack,
  input  logic                        hc_write,
  input  logic                        hc_reg_sel,
  input  usb_bridge_pkg::data_t       hc_wdata,
  output usb_bridge_pkg::data_t       hc_rdata,
  output logic                        hc_irq_n,
  input  logic                        dc_req,
  output logic                        dc_ack,
  input  logic                        dc_write,
  input  logic                        dc_reg_sel,
  input  usb_bridge_pkg::data_t       dc_wdata,
  output usb_bridge_pkg::data_t       dc_rdata,
  output logic                        dc_irq_n,
  output usb_bridge_pkg::chip_addr_t  usb_addr,
  output usb_bridge_pkg::data_t       usb_data_out,
  output logic                        usb_data_oe,
  input  usb_bridge_pkg::data_t       usb_data_in,
  output logic                        usb_cs_n,
  output logic                        usb_rd_n,
  output logic                        usb_wr_n,
  output logic                        usb_rst_n,
  input  logic                        usb_int0,
  input  logic                        usb_int1
);

  bus_access_if hc_link ();
  bus_access_if dc_link ();
  bus_access_if seq_link ();

  // usb_int0 belongs to the host controller and usb_int1 to the device controller.
  host_port i_hc_port (
    .clk          (clk),
    .rst_n        (rst_n),
    .port_id      (usb_bridge_pkg::port_hc),
    .host_req     (hc_req),
    .host_write   (hc_write),
    .host_reg_sel (hc_reg_sel),
    .host_wdata   (hc_wdata),
    .host_ack     (hc_ack),
    .host_rdata   (hc_rdata),
    .chip_int     (usb_int0),
    .irq_n        (hc_irq_n),
    .link         (hc_link.requester)
  );

  host_port i_dc_port (
    .clk          (clk),
    .rst_n        (rst_n),
    .port_id      (usb_bridge_pkg::port_dc),
    .host_req     (dc_req),
    .host_write   (dc_write),
    .host_reg_sel (dc_reg_sel),
    .host_wdata   (dc_wdata),
    .host_ack     (dc_ack),
    .host_rdata   (dc_rdata),
    .chip_int     (usb_int1),
    .irq_n        (dc_irq_n),
    .link         (dc_link.requester)
  );

  access_arbiter i_arbiter (
    .clk      (clk),
    .rst_n    (rst_n),
    .hc_link  (hc_link.responder),
    .dc_link  (dc_link.responder),
    .seq_link (seq_link.requester)
  );

  chip_bus_sequencer i_sequencer (
    .clk          (clk),
    .rst_n        (rst_n),
    .link         (seq_link.responder),
    .usb_addr     (usb_addr),
    .usb_data_out (usb_data_out),
    .usb_data_oe  (usb_data_oe),
    .usb_data_in  (usb_data_in),
    .usb_cs_n     (usb_cs_n),
    .usb_rd_n     (usb_rd_n),
    .usb_wr_n     (usb_wr_n),
    .usb_rst_n    (usb_rst_n)
  );

endmodule
